//--- hw/lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_id_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [2:0]  size_t;
    typedef logic [2:0]  mem_op_t;
    typedef logic [4:0]  exc_code_t;

    // access size codes, as carried on the memory request.
    localparam size_t SIZE_BYTE = 3'd0;
    localparam size_t SIZE_HALF = 3'd1;
    localparam size_t SIZE_WORD = 3'd2;

    // loads come first, so every store code is at or above OP_SB.
    localparam mem_op_t OP_LB  = 3'd0;
    localparam mem_op_t OP_LBU = 3'd1;
    localparam mem_op_t OP_LH  = 3'd2;
    localparam mem_op_t OP_LHU = 3'd3;
    localparam mem_op_t OP_LW  = 3'd4;
    localparam mem_op_t OP_SB  = 3'd5;
    localparam mem_op_t OP_SH  = 3'd6;
    localparam mem_op_t OP_SW  = 3'd7;

    // address error on load and on store.
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;

    // a tracking entry is {write, op, addr[1:0], reg}.
    localparam int PENDING_W      = 11;
    localparam int PEND_WRITE_BIT = 10;
    localparam int PEND_OP_LSB    = 7;
    localparam int PEND_LO_LSB    = 5;
    localparam int PEND_REG_LSB   = 0;

    typedef logic [PENDING_W-1:0] pending_t;

endpackage

//--- hw/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch #(
    parameter int RESET_STRETCH_W = 4
) (
    input  logic Clk,
    input  logic Myreset,
    output logic o_core_reset
);

    logic [RESET_STRETCH_W-1:0] count;
    logic                       released;

    // the count starts on the first edge with Myreset low and the core
    // leaves reset on the edge that sees the counter full.
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            count    <= '0;
            released <= 1'b0;
        end else if (!released) begin
            count <= count + 1'b1;
            if (&count) begin
                released <= 1'b1;
            end
        end
    end

    assign o_core_reset = Myreset || !released;

endmodule

//--- hw/lsu_issue.sv
`timescale 1ns/1ps

module lsu_issue #(
    parameter int MEM_CREDITS = 4
) (
    input  logic                Clk,
    input  logic                i_core_reset,
    input  logic                i_op_valid,
    input  lsu_pkg::mem_op_t    i_op_kind,
    input  lsu_pkg::word_t      i_op_addr,
    input  lsu_pkg::word_t      i_op_wdata,
    input  lsu_pkg::reg_id_t    i_op_reg,
    input  logic                i_mem_credit_return,
    input  logic                i_queue_full,
    output logic                o_op_ready,
    output logic                o_mem_req_valid,
    output logic                o_mem_req_write,
    output lsu_pkg::word_t      o_mem_req_addr,
    output lsu_pkg::byte_en_t   o_mem_req_byte_en,
    output lsu_pkg::size_t      o_mem_req_size,
    output lsu_pkg::word_t      o_mem_req_wdata,
    output logic                o_exc_valid,
    output lsu_pkg::exc_code_t  o_exc_code,
    output lsu_pkg::word_t      o_exc_badvaddr,
    output logic                o_push,
    output lsu_pkg::pending_t   o_push_entry
);

    localparam int CRED_W = $clog2(MEM_CREDITS + 1);

    logic [CRED_W-1:0]  credits;
    logic               accept;
    logic               spend;
    logic               is_store;
    logic               misaligned;
    lsu_pkg::size_t     size;
    lsu_pkg::byte_en_t  byte_en;
    lsu_pkg::word_t     wdata_lanes;

    assign o_op_ready = !i_core_reset && (credits != '0) && !i_queue_full;
    assign accept     = i_op_valid && o_op_ready;
    // a misaligned operation ends in the exception and never reaches memory.
    assign spend      = accept && !misaligned;

    assign is_store = (i_op_kind == lsu_pkg::OP_SB) || (i_op_kind == lsu_pkg::OP_SH)
                   || (i_op_kind == lsu_pkg::OP_SW);

    always_comb begin
        case (i_op_kind)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: size = lsu_pkg::SIZE_BYTE;
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: size = lsu_pkg::SIZE_HALF;
            default:                                         size = lsu_pkg::SIZE_WORD;
        endcase
    end

    assign misaligned = ((size == lsu_pkg::SIZE_HALF) && i_op_addr[0])
                     || ((size == lsu_pkg::SIZE_WORD) && (i_op_addr[1:0] != 2'b00));

    // store data goes out on every lane the access could use.
    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                byte_en     = 4'b0001 << i_op_addr[1:0];
                wdata_lanes = {4{i_op_wdata[7:0]}};
            end
            lsu_pkg::SIZE_HALF: begin
                byte_en     = i_op_addr[1] ? 4'b1100 : 4'b0011;
                wdata_lanes = {2{i_op_wdata[15:0]}};
            end
            default: begin
                byte_en     = 4'b1111;
                wdata_lanes = i_op_wdata;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            credits         <= CRED_W'(MEM_CREDITS);
            o_mem_req_valid <= 1'b0;
            o_exc_valid     <= 1'b0;
        end else begin
            o_mem_req_valid <= spend;
            o_exc_valid     <= accept && misaligned;
            if (spend && !i_mem_credit_return) begin
                credits <= credits - 1'b1;
            end else if (!spend && i_mem_credit_return) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            o_mem_req_write   <= is_store;
            o_mem_req_addr    <= {i_op_addr[31:2], 2'b00};
            o_mem_req_byte_en <= byte_en;
            o_mem_req_size    <= size;
            o_mem_req_wdata   <= wdata_lanes;
            o_exc_code        <= is_store ? lsu_pkg::EXC_ADES : lsu_pkg::EXC_ADEL;
            o_exc_badvaddr    <= i_op_addr;
            o_push_entry[lsu_pkg::PEND_WRITE_BIT]      <= is_store;
            o_push_entry[lsu_pkg::PEND_OP_LSB +: 3]    <= i_op_kind;
            o_push_entry[lsu_pkg::PEND_LO_LSB +: 2]    <= i_op_addr[1:0];
            o_push_entry[lsu_pkg::PEND_REG_LSB +: 5]   <= i_op_reg;
        end
    end

    // the tracking entry enters the queue together with its request.
    assign o_push = o_mem_req_valid;

endmodule

//--- hw/lsu_pending_fifo.sv
`timescale 1ns/1ps

module lsu_pending_fifo #(
    parameter int PENDING_DEPTH = 4
) (
    input  logic               Clk,
    input  logic               i_core_reset,
    input  logic               i_push,
    input  lsu_pkg::pending_t  i_push_entry,
    input  logic               i_pop,
    output lsu_pkg::pending_t  o_head,
    output logic               o_full,
    output logic               o_empty
);

    localparam int PTR_W = (PENDING_DEPTH > 1) ? $clog2(PENDING_DEPTH) : 1;
    localparam int CNT_W = $clog2(PENDING_DEPTH + 1);

    lsu_pkg::pending_t  entries [PENDING_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign o_full  = (count == CNT_W'(PENDING_DEPTH));
    assign o_empty = (count == '0);
    assign o_head  = entries[rd_ptr];

    // a push into a full queue is only taken when the head leaves in the same cycle.
    assign do_push = i_push && (!o_full || i_pop);
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(PENDING_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(PENDING_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (do_push) begin
            entries[wr_ptr] <= i_push_entry;
        end
    end

endmodule

//--- hw/lsu_writeback.sv
`timescale 1ns/1ps

module lsu_writeback (
    input  logic               Clk,
    input  logic               i_core_reset,
    input  logic               i_mem_rsp_valid,
    input  lsu_pkg::word_t     i_mem_rsp_rdata,
    input  lsu_pkg::pending_t  i_head,
    output logic               o_pop,
    output logic               o_wb_valid,
    output lsu_pkg::reg_id_t   o_wb_reg,
    output lsu_pkg::word_t     o_wb_data
);

    logic              is_write;
    lsu_pkg::mem_op_t  op;
    logic [1:0]        lo;
    lsu_pkg::reg_id_t  rd;
    logic [7:0]        sel_byte;
    logic [15:0]       sel_half;
    lsu_pkg::word_t    ext_data;

    assign is_write = i_head[lsu_pkg::PEND_WRITE_BIT];
    assign op       = i_head[lsu_pkg::PEND_OP_LSB +: 3];
    assign lo       = i_head[lsu_pkg::PEND_LO_LSB +: 2];
    assign rd       = i_head[lsu_pkg::PEND_REG_LSB +: 5];

    // responses come back in request order, so the head always belongs to this one.
    assign o_pop = i_mem_rsp_valid;

    assign sel_byte = i_mem_rsp_rdata[{lo, 3'b000} +: 8];
    assign sel_half = lo[1] ? i_mem_rsp_rdata[31:16] : i_mem_rsp_rdata[15:0];

    always_comb begin
        case (op)
            lsu_pkg::OP_LB:  ext_data = {{24{sel_byte[7]}}, sel_byte};
            lsu_pkg::OP_LBU: ext_data = {24'h000000, sel_byte};
            lsu_pkg::OP_LH:  ext_data = {{16{sel_half[15]}}, sel_half};
            lsu_pkg::OP_LHU: ext_data = {16'h0000, sel_half};
            default:         ext_data = i_mem_rsp_rdata;
        endcase
    end

    // stores and loads into register 0 retire without a register write.
    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_mem_rsp_valid && !is_write && (rd != '0);
        end
    end

    always_ff @(posedge Clk) begin
        if (i_mem_rsp_valid) begin
            o_wb_reg  <= rd;
            o_wb_data <= ext_data;
        end
    end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter int RESET_STRETCH_W = 4,
    parameter int MEM_CREDITS     = 4,
    parameter int PENDING_DEPTH   = 4
) (
    input  logic                Clk,
    input  logic                Myreset,
    input  logic                i_op_valid,
    input  lsu_pkg::mem_op_t    i_op_kind,
    input  lsu_pkg::word_t      i_op_addr,
    input  lsu_pkg::word_t      i_op_wdata,
    input  lsu_pkg::reg_id_t    i_op_reg,
    output logic                o_op_ready,
    output logic                o_mem_req_valid,
    output logic                o_mem_req_write,
    output lsu_pkg::word_t      o_mem_req_addr,
    output lsu_pkg::byte_en_t   o_mem_req_byte_en,
    output lsu_pkg::size_t      o_mem_req_size,
    output lsu_pkg::word_t      o_mem_req_wdata,
    input  logic                i_mem_credit_return,
    input  logic                i_mem_rsp_valid,
    input  lsu_pkg::word_t      i_mem_rsp_rdata,
    output logic                o_exc_valid,
    output lsu_pkg::exc_code_t  o_exc_code,
    output lsu_pkg::word_t      o_exc_badvaddr,
    output logic                o_wb_valid,
    output lsu_pkg::reg_id_t    o_wb_reg,
    output lsu_pkg::word_t      o_wb_data
);

    logic               core_reset;
    logic               queue_full;
    logic               queue_empty;
    logic               push;
    logic               pop;
    lsu_pkg::pending_t  push_entry;
    lsu_pkg::pending_t  head;

    reset_stretch #(
        .RESET_STRETCH_W(RESET_STRETCH_W)
    ) reset_stretch_i (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .o_core_reset (core_reset)
    );

    lsu_issue #(
        .MEM_CREDITS(MEM_CREDITS)
    ) lsu_issue_i (
        .Clk                 (Clk),
        .i_core_reset        (core_reset),
        .i_op_valid          (i_op_valid),
        .i_op_kind           (i_op_kind),
        .i_op_addr           (i_op_addr),
        .i_op_wdata          (i_op_wdata),
        .i_op_reg            (i_op_reg),
        .i_mem_credit_return (i_mem_credit_return),
        .i_queue_full        (queue_full),
        .o_op_ready          (o_op_ready),
        .o_mem_req_valid     (o_mem_req_valid),
        .o_mem_req_write     (o_mem_req_write),
        .o_mem_req_addr      (o_mem_req_addr),
        .o_mem_req_byte_en   (o_mem_req_byte_en),
        .o_mem_req_size      (o_mem_req_size),
        .o_mem_req_wdata     (o_mem_req_wdata),
        .o_exc_valid         (o_exc_valid),
        .o_exc_code          (o_exc_code),
        .o_exc_badvaddr      (o_exc_badvaddr),
        .o_push              (push),
        .o_push_entry        (push_entry)
    );

    lsu_pending_fifo #(
        .PENDING_DEPTH(PENDING_DEPTH)
    ) lsu_pending_fifo_i (
        .Clk          (Clk),
        .i_core_reset (core_reset),
        .i_push       (push),
        .i_push_entry (push_entry),
        .i_pop        (pop),
        .o_head       (head),
        .o_full       (queue_full),
        .o_empty      (queue_empty)
    );

    lsu_writeback lsu_writeback_i (
        .Clk             (Clk),
        .i_core_reset    (core_reset),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp_rdata (i_mem_rsp_rdata),
        .i_head          (head),
        .o_pop           (pop),
        .o_wb_valid      (o_wb_valid),
        .o_wb_reg        (o_wb_reg),
        .o_wb_data       (o_wb_data)
    );

endmodule

//--- bench/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                Clk,
    input  logic                i_rst,
    input  logic                i_req_valid,
    input  logic                i_req_write,
    input  lsu_pkg::word_t      i_req_addr,
    input  lsu_pkg::byte_en_t   i_req_byte_en,
    input  lsu_pkg::word_t      i_req_wdata,
    output logic                o_rsp_valid,
    output lsu_pkg::word_t      o_rsp_rdata,
    output logic                o_credit_return
);

    logic [7:0]       mem [256];
    logic             write_q [$];
    logic [7:0]       addr_q [$];
    logic [3:0]       be_q [$];
    lsu_pkg::word_t   wdata_q [$];
    int               due_q [$];
    int               cycle;
    int               last_due;

    function automatic logic [7:0] fill_byte(int a);
        return 8'((a * 29 + 11) ^ (a >> 4));
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_byte(i);
        end
        cycle           = 0;
        last_due        = 0;
        o_rsp_valid     = 1'b0;
        o_rsp_rdata     = '0;
        o_credit_return = 1'b0;
    end

    // requests are taken and responses driven on the falling edge; the
    // response to each request waits 1 to 8 cycles and never overtakes an older one.
    always @(negedge Clk) begin
        int         lat;
        int         due;
        logic [7:0] a;
        cycle           = cycle + 1;
        o_rsp_valid     = 1'b0;
        o_credit_return = 1'b0;
        if (i_rst) begin
            write_q.delete();
            addr_q.delete();
            be_q.delete();
            wdata_q.delete();
            due_q.delete();
        end else begin
            if (i_req_valid) begin
                lat = int'($urandom_range(8, 1));
                due = cycle + lat;
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                write_q.push_back(i_req_write);
                addr_q.push_back(i_req_addr[7:0]);
                be_q.push_back(i_req_byte_en);
                wdata_q.push_back(i_req_wdata);
                due_q.push_back(due);
            end
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                a = {addr_q[0][7:2], 2'b00};
                if (write_q[0]) begin
                    for (int i = 0; i < 4; i++) begin
                        if (be_q[0][i]) begin
                            mem[a + 8'(i)] = wdata_q[0][8*i +: 8];
                        end
                    end
                end else begin
                    o_rsp_rdata = {mem[a + 8'd3], mem[a + 8'd2], mem[a + 8'd1], mem[a]};
                end
                void'(write_q.pop_front());
                void'(addr_q.pop_front());
                void'(be_q.pop_front());
                void'(wdata_q.pop_front());
                void'(due_q.pop_front());
                o_rsp_valid     = 1'b1;
                o_credit_return = 1'b1;
            end
        end
    end

endmodule

//--- bench/lsu_assertions.sv
`timescale 1ns/1ps

module lsu_assertions #(
    parameter int MEM_CREDITS = 4
) (
    input logic Clk,
    input logic i_rst,
    input logic i_req_valid,
    input logic i_credit_return,
    input logic i_push,
    input logic i_pop,
    input logic i_queue_full,
    input logic i_queue_empty
);

    int outstanding;

    // requests sent and not yet answered, each of them holding one credit.
    always_ff @(posedge Clk) begin
        if (i_rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(i_req_valid) - int'(i_credit_return);
        end
    end

    credits_in_range: assert property (@(posedge Clk) disable iff (i_rst)
        (outstanding >= 0) && (outstanding <= MEM_CREDITS))
        else $error("outstanding requests outside the credit range");

    push_has_room: assert property (@(posedge Clk) disable iff (i_rst)
        i_push |-> (!i_queue_full || i_pop))
        else $error("tracking entry pushed into a full queue");

    rsp_has_entry: assert property (@(posedge Clk) disable iff (i_rst)
        i_pop |-> !i_queue_empty)
        else $error("memory response with nothing outstanding");

endmodule

bind lsu_top lsu_assertions #(
    .MEM_CREDITS(MEM_CREDITS)
) lsu_checks_i (
    .Clk             (Clk),
    .i_rst           (core_reset),
    .i_req_valid     (o_mem_req_valid),
    .i_credit_return (i_mem_credit_return),
    .i_push          (push),
    .i_pop           (pop),
    .i_queue_full    (queue_full),
    .i_queue_empty   (queue_empty)
);

//--- bench/tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top;

    localparam int MAX_CYCLES  = 20000;
    localparam int RANDOM_OPS  = 300;
    localparam int STRETCH_LEN = 16;

    logic                Clk;
    logic                Myreset;
    logic                i_op_valid;
    lsu_pkg::mem_op_t    i_op_kind;
    lsu_pkg::word_t      i_op_addr;
    lsu_pkg::word_t      i_op_wdata;
    lsu_pkg::reg_id_t    i_op_reg;
    logic                o_op_ready;
    logic                o_mem_req_valid;
    logic                o_mem_req_write;
    lsu_pkg::word_t      o_mem_req_addr;
    lsu_pkg::byte_en_t   o_mem_req_byte_en;
    lsu_pkg::size_t      o_mem_req_size;
    lsu_pkg::word_t      o_mem_req_wdata;
    logic                mem_credit_return;
    logic                mem_rsp_valid;
    lsu_pkg::word_t      mem_rsp_rdata;
    logic                o_exc_valid;
    lsu_pkg::exc_code_t  o_exc_code;
    lsu_pkg::word_t      o_exc_badvaddr;
    logic                o_wb_valid;
    lsu_pkg::reg_id_t    o_wb_reg;
    lsu_pkg::word_t      o_wb_data;

    logic [7:0]          shadow [256];
    lsu_pkg::reg_id_t    wb_reg_q [$];
    lsu_pkg::word_t      wb_data_q [$];
    lsu_pkg::exc_code_t  exc_code_q [$];
    lsu_pkg::word_t      exc_addr_q [$];
    lsu_pkg::size_t      req_size_q [$];
    lsu_pkg::byte_en_t   req_be_q [$];
    int                  check_errors;
    int                  wb_seen;
    int                  exc_seen;
    int                  stall_cycles;
    int                  cycles;
    logic                checking;

    lsu_top dut_i (
        .Clk(Clk), .Myreset(Myreset),
        .i_op_valid(i_op_valid), .i_op_kind(i_op_kind), .i_op_addr(i_op_addr),
        .i_op_wdata(i_op_wdata), .i_op_reg(i_op_reg), .o_op_ready(o_op_ready),
        .o_mem_req_valid(o_mem_req_valid), .o_mem_req_write(o_mem_req_write),
        .o_mem_req_addr(o_mem_req_addr), .o_mem_req_byte_en(o_mem_req_byte_en),
        .o_mem_req_size(o_mem_req_size), .o_mem_req_wdata(o_mem_req_wdata),
        .i_mem_credit_return(mem_credit_return), .i_mem_rsp_valid(mem_rsp_valid),
        .i_mem_rsp_rdata(mem_rsp_rdata), .o_exc_valid(o_exc_valid),
        .o_exc_code(o_exc_code), .o_exc_badvaddr(o_exc_badvaddr),
        .o_wb_valid(o_wb_valid), .o_wb_reg(o_wb_reg), .o_wb_data(o_wb_data)
    );

    mem_model mem_i (
        .Clk(Clk), .i_rst(Myreset),
        .i_req_valid(o_mem_req_valid), .i_req_write(o_mem_req_write),
        .i_req_addr(o_mem_req_addr), .i_req_byte_en(o_mem_req_byte_en),
        .i_req_wdata(o_mem_req_wdata),
        .o_rsp_valid(mem_rsp_valid), .o_rsp_rdata(mem_rsp_rdata),
        .o_credit_return(mem_credit_return)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // the shadow starts from the same address pattern as the memory model.
    function automatic logic [7:0] initial_byte(int a);
        return 8'((a * 29 + 11) ^ (a >> 4));
    endfunction

    // expected result of one accepted operation, from the access rules alone.
    function automatic void predict_op(lsu_pkg::mem_op_t kind, lsu_pkg::word_t addr,
                                       lsu_pkg::word_t wdata, lsu_pkg::reg_id_t rd);
        logic [7:0]        a;
        logic              store;
        logic              bad;
        int                nbytes;
        lsu_pkg::size_t    sz;
        lsu_pkg::byte_en_t be;
        logic [15:0]       h;
        lsu_pkg::word_t    expv;
        a     = addr[7:0];
        store = (kind == lsu_pkg::OP_SB) || (kind == lsu_pkg::OP_SH) || (kind == lsu_pkg::OP_SW);
        case (kind)
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: begin
                bad    = addr[0];
                nbytes = 2;
                sz     = lsu_pkg::SIZE_HALF;
            end
            lsu_pkg::OP_LW, lsu_pkg::OP_SW: begin
                bad    = (addr[1:0] != 2'b00);
                nbytes = 4;
                sz     = lsu_pkg::SIZE_WORD;
            end
            default: begin
                bad    = 1'b0;
                nbytes = 1;
                sz     = lsu_pkg::SIZE_BYTE;
            end
        endcase
        expv = '0;
        h    = {shadow[a + 8'd1], shadow[a]};
        if (bad) begin
            exc_code_q.push_back(store ? lsu_pkg::EXC_ADES : lsu_pkg::EXC_ADEL);
            exc_addr_q.push_back(addr);
        end else begin
            // one lane per byte of the access, starting at the addressed lane.
            be = '0;
            for (int i = 0; i < nbytes; i++) begin
                be[addr[1:0] + 2'(i)] = 1'b1;
            end
            req_size_q.push_back(sz);
            req_be_q.push_back(be);
            case (kind)
                lsu_pkg::OP_SB: shadow[a] = wdata[7:0];
                lsu_pkg::OP_SH: begin
                    shadow[a]        = wdata[7:0];
                    shadow[a + 8'd1] = wdata[15:8];
                end
                lsu_pkg::OP_SW: begin
                    shadow[a]        = wdata[7:0];
                    shadow[a + 8'd1] = wdata[15:8];
                    shadow[a + 8'd2] = wdata[23:16];
                    shadow[a + 8'd3] = wdata[31:24];
                end
                lsu_pkg::OP_LB:  expv = {{24{shadow[a][7]}}, shadow[a]};
                lsu_pkg::OP_LBU: expv = {24'h000000, shadow[a]};
                lsu_pkg::OP_LH:  expv = {{16{h[15]}}, h};
                lsu_pkg::OP_LHU: expv = {16'h0000, h};
                default: expv = {shadow[a + 8'd3], shadow[a + 8'd2], shadow[a + 8'd1], shadow[a]};
            endcase
            if (!store && rd != '0) begin
                wb_reg_q.push_back(rd);
                wb_data_q.push_back(expv);
            end
        end
    endfunction

    // entered on a falling edge; returns on the falling edge after acceptance.
    task automatic send_op(lsu_pkg::mem_op_t kind, lsu_pkg::word_t addr,
                           lsu_pkg::word_t wdata, lsu_pkg::reg_id_t rd);
        i_op_valid = 1'b1;
        i_op_kind  = kind;
        i_op_addr  = addr;
        i_op_wdata = wdata;
        i_op_reg   = rd;
        while (!o_op_ready) begin
            @(negedge Clk);
        end
        predict_op(kind, addr, wdata, rd);
        @(negedge Clk);
        i_op_valid = 1'b0;
    endtask

    task automatic send_random_op();
        lsu_pkg::mem_op_t kind;
        lsu_pkg::word_t   addr;
        kind = lsu_pkg::mem_op_t'($urandom_range(7, 0));
        addr = lsu_pkg::word_t'($urandom_range(255, 0));
        // most accesses are aligned so that loads and stores really hit memory.
        if ($urandom_range(7, 0) != 0) begin
            if (kind == lsu_pkg::OP_LW || kind == lsu_pkg::OP_SW) begin
                addr[1:0] = 2'b00;
            end else if (kind == lsu_pkg::OP_LH || kind == lsu_pkg::OP_LHU
                         || kind == lsu_pkg::OP_SH) begin
                addr[0] = 1'b0;
            end
        end
        send_op(kind, addr, $urandom, lsu_pkg::reg_id_t'($urandom_range(31, 0)));
    endtask

    always @(posedge Clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with operations still pending", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    always @(posedge Clk) begin
        if (checking && i_op_valid && !o_op_ready) begin
            stall_cycles = stall_cycles + 1;
        end
    end

    always @(negedge Clk) begin
        lsu_pkg::reg_id_t   exp_reg;
        lsu_pkg::word_t     exp_data;
        lsu_pkg::exc_code_t exp_code;
        lsu_pkg::size_t     exp_size;
        lsu_pkg::byte_en_t  exp_be;
        if (checking && o_mem_req_valid) begin
            assert (req_size_q.size() != 0) else begin
                check_errors = check_errors + 1;
                $display("unexpected memory request at %0t for address %h",
                         $time, o_mem_req_addr);
            end
            if (req_size_q.size() != 0) begin
                exp_size = req_size_q.pop_front();
                exp_be   = req_be_q.pop_front();
                assert (o_mem_req_size == exp_size) else begin
                    check_errors = check_errors + 1;
                    $display("Mismatch at %0t: o_mem_req_size got %0d expected %0d",
                             $time, o_mem_req_size, exp_size);
                end
                assert (o_mem_req_byte_en == exp_be) else begin
                    check_errors = check_errors + 1;
                    $display("Mismatch at %0t: o_mem_req_byte_en got %b expected %b",
                             $time, o_mem_req_byte_en, exp_be);
                end
            end
        end
        if (checking && o_wb_valid) begin
            assert (wb_reg_q.size() != 0) else begin
                check_errors = check_errors + 1;
                $display("unexpected writeback at %0t to register %0d", $time, o_wb_reg);
            end
            if (wb_reg_q.size() != 0) begin
                exp_reg  = wb_reg_q.pop_front();
                exp_data = wb_data_q.pop_front();
                wb_seen  = wb_seen + 1;
                assert (o_wb_reg == exp_reg) else begin
                    check_errors = check_errors + 1;
                    $display("Mismatch at %0t: o_wb_reg got %0d expected %0d",
                             $time, o_wb_reg, exp_reg);
                end
                assert (o_wb_data == exp_data) else begin
                    check_errors = check_errors + 1;
                    $display("Mismatch at %0t: o_wb_data got %h expected %h",
                             $time, o_wb_data, exp_data);
                end
            end
        end
        if (checking && o_exc_valid) begin
            assert (exc_code_q.size() != 0) else begin
                check_errors = check_errors + 1;
                $display("unexpected exception at %0t for address %h", $time, o_exc_badvaddr);
            end
            if (exc_code_q.size() != 0) begin
                exp_code = exc_code_q.pop_front();
                exp_data = exc_addr_q.pop_front();
                exc_seen = exc_seen + 1;
                assert (o_exc_code == exp_code) else begin
                    check_errors = check_errors + 1;
                    $display("Mismatch at %0t: o_exc_code got %0d expected %0d",
                             $time, o_exc_code, exp_code);
                end
                assert (o_exc_badvaddr == exp_data) else begin
                    check_errors = check_errors + 1;
                    $display("Mismatch at %0t: o_exc_badvaddr got %h expected %h",
                             $time, o_exc_badvaddr, exp_data);
                end
            end
        end
    end

    initial begin
        int stretch;
        int flow_errors;
        void'($urandom(32'h9eeed268));
        Myreset      = 1'b1;
        i_op_valid   = 1'b0;
        i_op_kind    = lsu_pkg::OP_LW;
        i_op_addr    = '0;
        i_op_wdata   = '0;
        i_op_reg     = '0;
        checking     = 1'b0;
        check_errors = 0;
        flow_errors  = 0;
        wb_seen      = 0;
        exc_seen     = 0;
        stall_cycles = 0;
        cycles       = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = initial_byte(i);
        end
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        Myreset = 1'b0;
        checking = 1'b1;
        stretch = 0;
        while (!o_op_ready) begin
            @(negedge Clk);
            stretch = stretch + 1;
        end
        assert (stretch == STRETCH_LEN) else begin
            flow_errors = flow_errors + 1;
            $display("Mismatch at %0t: o_op_ready low cycles got %0d expected %0d",
                     $time, stretch, STRETCH_LEN);
        end

        send_op(lsu_pkg::OP_SW, 32'h40, 32'h8899aabb, 5'd1);
        send_op(lsu_pkg::OP_SH, 32'h44, 32'h1234f00d, 5'd1);
        send_op(lsu_pkg::OP_SH, 32'h46, 32'h00007ffe, 5'd1);
        send_op(lsu_pkg::OP_SB, 32'h48, 32'h00000081, 5'd1);
        send_op(lsu_pkg::OP_SB, 32'h49, 32'h0000007f, 5'd1);
        send_op(lsu_pkg::OP_SB, 32'h4a, 32'h000000c3, 5'd1);
        send_op(lsu_pkg::OP_SB, 32'h4b, 32'h00000005, 5'd1);
        send_op(lsu_pkg::OP_LW, 32'h40, '0, 5'd2);
        send_op(lsu_pkg::OP_LB, 32'h40, '0, 5'd3);
        send_op(lsu_pkg::OP_LB, 32'h43, '0, 5'd3);
        send_op(lsu_pkg::OP_LBU, 32'h41, '0, 5'd4);
        send_op(lsu_pkg::OP_LH, 32'h40, '0, 5'd5);
        send_op(lsu_pkg::OP_LH, 32'h42, '0, 5'd6);
        send_op(lsu_pkg::OP_LHU, 32'h42, '0, 5'd7);
        send_op(lsu_pkg::OP_LHU, 32'h44, '0, 5'd7);
        send_op(lsu_pkg::OP_LH, 32'h46, '0, 5'd8);
        send_op(lsu_pkg::OP_LW, 32'h48, '0, 5'd9);
        send_op(lsu_pkg::OP_LB, 32'h48, '0, 5'd10);
        send_op(lsu_pkg::OP_LBU, 32'h48, '0, 5'd11);
        send_op(lsu_pkg::OP_LB, 32'h49, '0, 5'd12);
        send_op(lsu_pkg::OP_LW, 32'h44, '0, 5'd13);

        send_op(lsu_pkg::OP_LH, 32'h41, '0, 5'd14);
        send_op(lsu_pkg::OP_LW, 32'h42, '0, 5'd15);
        send_op(lsu_pkg::OP_SH, 32'h43, 32'h5555aaaa, 5'd0);
        send_op(lsu_pkg::OP_SW, 32'h45, 32'h01020304, 5'd0);
        send_op(lsu_pkg::OP_LW, 32'h40, '0, 5'd16);

        send_op(lsu_pkg::OP_LW, 32'h40, '0, 5'd0);
        send_op(lsu_pkg::OP_LB, 32'h48, '0, 5'd0);
        send_op(lsu_pkg::OP_SW, 32'h50, 32'hdeadbeef, 5'd0);
        send_op(lsu_pkg::OP_LW, 32'h50, '0, 5'd17);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            send_random_op();
        end

        while (wb_reg_q.size() != 0 || exc_code_q.size() != 0 || req_size_q.size() != 0) begin
            @(negedge Clk);
        end
        repeat (60) @(negedge Clk);
        assert (stall_cycles > 0) else begin
            flow_errors = flow_errors + 1;
            $display("operation input was never held back by exhausted credits");
        end

        $display("errors: %0d check, %0d flow; writebacks %0d, exceptions %0d, stalls %0d",
                 check_errors, flow_errors, wb_seen, exc_seen, stall_cycles);
        if (check_errors == 0 && flow_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/lsu_pkg.sv
hw/reset_stretch.sv
hw/lsu_issue.sv
hw/lsu_pending_fifo.sv
hw/lsu_writeback.sv
hw/lsu_top.sv
bench/mem_model.sv
bench/lsu_assertions.sv
bench/tb_lsu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
